// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -j 0
TB_TOP      = video_gen_tb
RTL_TOP     = video_gen
FILELIST    = src.f
OBJ_DIR     = obj_dir
PASS_MSG    = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/video_border.sv
src/video_gen.sv
testbench/video_gen_tb.sv

// File: src/video_border.sv
/*
 * video_border
 * Window test and pixel output stage. Pixels inside the window show
 * the playfield colour base, the rest of the screen shows the border.
 */
`default_nettype none
`timescale 1ns/1ps

module video_border (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire video_pkg::hres_t   h_count_i,
    input  wire video_pkg::vres_t   v_count_i,
    input  wire logic               h_visible_i,
    input  wire logic               v_visible_i,
    input  wire video_pkg::color_t  border_color_i,
    input  wire video_pkg::color_t  colorbase_i,
    input  wire logic               pf_blank_i,
    input  wire video_pkg::vres_t   vid_top_i,
    input  wire video_pkg::vres_t   vid_bottom_i,
    input  wire video_pkg::hres_t   vid_left_i,
    input  wire video_pkg::hres_t   vid_right_i,
    output      video_pkg::color_t  color_index_o,
    output      logic               dv_de_o
);
    import video_pkg::*;

    hres_t  vis_x;                                  // x within visible area
    logic   in_display;
    logic   in_window;

    assign vis_x      = h_count_i - hres_t'(OFFSCREEN_WIDTH);
    assign in_display = h_visible_i && v_visible_i;
    assign in_window  = (vis_x >= vid_left_i) && (vis_x < vid_right_i) &&
                        (v_count_i >= vid_top_i) && (v_count_i < vid_bottom_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dv_de_o       <= 1'b0;
            color_index_o <= 8'h00;
        end else begin
            dv_de_o <= in_display;
            if (!in_display) begin
                color_index_o <= 8'h00;             // black during blanking
            end else if (in_window && !pf_blank_i) begin
                color_index_o <= colorbase_i;
            end else begin
                color_index_o <= border_color_i;
            end
        end
    end

endmodule
`default_nettype wire

// File: src/video_gen.sv
/*
 * video_gen
 * Top of the video timing and border generator. Ties the sync
 * timing, configuration registers and border output stage together.
 */
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_en_i,
    input  wire video_pkg::reg_num_t    reg_num_i,
    input  wire video_pkg::word_t       reg_data_i,
    input  wire logic [3:0]             intr_status_i,
    output      video_pkg::word_t       reg_data_o,
    output      logic [3:0]             intr_signal_o,
    output      video_pkg::color_t      color_index_o,
    output      logic                   hsync_o,
    output      logic                   vsync_o,
    output      logic                   dv_de_o
);
    import video_pkg::*;

    hres_t  h_count;
    vres_t  v_count;
    logic   h_visible;
    logic   v_visible;
    logic   frame_end;
    color_t border_color;
    color_t colorbase;
    logic   pf_blank;
    vres_t  vid_top;
    vres_t  vid_bottom;
    hres_t  vid_left;
    hres_t  vid_right;

    video_timing video_timing_i (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count),
        .h_visible_o(h_visible), .v_visible_o(v_visible),
        .frame_end_o(frame_end),
        .hsync_o(hsync_o), .vsync_o(vsync_o)
    );

    video_regs video_regs_i (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .v_count_i(v_count), .h_visible_i(h_visible), .v_visible_i(v_visible),
        .frame_end_i(frame_end),
        .border_color_o(border_color), .colorbase_o(colorbase), .pf_blank_o(pf_blank),
        .vid_top_o(vid_top), .vid_bottom_o(vid_bottom),
        .vid_left_o(vid_left), .vid_right_o(vid_right)
    );

    video_border video_border_i (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .v_count_i(v_count),
        .h_visible_i(h_visible), .v_visible_i(v_visible),
        .border_color_i(border_color), .colorbase_i(colorbase), .pf_blank_i(pf_blank),
        .vid_top_i(vid_top), .vid_bottom_i(vid_bottom),
        .vid_left_i(vid_left), .vid_right_i(vid_right),
        .color_index_o(color_index_o), .dv_de_o(dv_de_o)
    );

endmodule
`default_nettype wire

// File: src/video_pkg.sv
/*
 * video_pkg
 * Shared types, timing constants and register numbers for the
 * 640x480 video timing and border generator.
 */
package video_pkg;

    localparam int HRES_W   = 10;               // horizontal counter width
    localparam int VRES_W   = 10;               // vertical counter width

    typedef logic [15:0]        word_t;         // register data word
    typedef logic [7:0]         color_t;        // palette colour index
    typedef logic [HRES_W-1:0]  hres_t;
    typedef logic [VRES_W-1:0]  vres_t;
    typedef logic [4:0]         reg_num_t;

    // sync states, order matters since each state steps to the next by +1
    typedef enum logic [1:0] {
        STATE_PRE_SYNC  = 2'b00,
        STATE_SYNC      = 2'b01,
        STATE_POST_SYNC = 2'b10,
        STATE_VISIBLE   = 2'b11
    } vid_state_t;

    // 640x480 @ 60Hz, 25.175 MHz pixel clock
    localparam int VISIBLE_WIDTH    = 640;
    localparam int VISIBLE_HEIGHT   = 480;

    localparam int H_FRONT_PORCH    = 16;
    localparam int H_SYNC_PULSE     = 96;
    localparam int OFFSCREEN_WIDTH  = 160;      // porches plus sync, left of visible
    localparam int TOTAL_WIDTH      = 800;

    localparam int V_FRONT_PORCH    = 10;
    localparam int V_SYNC_PULSE     = 2;
    localparam int TOTAL_HEIGHT     = 525;

    localparam logic H_SYNC_POLARITY = 1'b0;    // active low
    localparam logic V_SYNC_POLARITY = 1'b0;    // active low

    localparam int REFRESH_FREQ     = 60;

    // configuration register numbers
    localparam reg_num_t XR_VID_CTRL    = 5'd0;
    localparam reg_num_t XR_VID_TOP     = 5'd2;
    localparam reg_num_t XR_VID_BOTTOM  = 5'd3;
    localparam reg_num_t XR_VID_LEFT    = 5'd4;
    localparam reg_num_t XR_VID_RIGHT   = 5'd5;
    localparam reg_num_t XR_SCANLINE    = 5'd6;
    localparam reg_num_t XR_VID_HSIZE   = 5'd7;
    localparam reg_num_t XR_VID_VSIZE   = 5'd8;
    localparam reg_num_t XR_VID_VFREQ   = 5'd9;
    localparam reg_num_t XR_PA_GFX_CTRL = 5'd16;

    localparam color_t BORDER_RESET_COLOR = 8'h08;  // dark grey, shows the core is alive

endpackage

// File: src/video_regs.sv
/*
 * video_regs
 * Configuration register file for the video generator. Writes land
 * on the strobe edge, reads come back through a registered port.
 * Also makes the frame and software interrupt pulses.
 */
`default_nettype none
`timescale 1ns/1ps

module video_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_en_i,    // write strobe
    input  wire video_pkg::reg_num_t    reg_num_i,
    input  wire video_pkg::word_t       reg_data_i,
    output      video_pkg::word_t       reg_data_o,
    input  wire logic [3:0]             intr_status_i,  // pending interrupt status
    output      logic [3:0]             intr_signal_o,
    input  wire video_pkg::vres_t       v_count_i,
    input  wire logic                   h_visible_i,
    input  wire logic                   v_visible_i,
    input  wire logic                   frame_end_i,
    output      video_pkg::color_t      border_color_o,
    output      video_pkg::color_t      colorbase_o,
    output      logic                   pf_blank_o,
    output      video_pkg::vres_t       vid_top_o,
    output      video_pkg::vres_t       vid_bottom_o,
    output      video_pkg::hres_t       vid_left_o,
    output      video_pkg::hres_t       vid_right_o
);
    import video_pkg::*;

    // register writes and interrupt pulses
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o  <= 4'b0;
            border_color_o <= BORDER_RESET_COLOR;
            colorbase_o    <= 8'h00;
            pf_blank_o     <= 1'b1;                 // playfield A blanked until enabled
            vid_top_o      <= '0;
            vid_bottom_o   <= vres_t'(VISIBLE_HEIGHT);
            vid_left_o     <= '0;
            vid_right_o    <= hres_t'(VISIBLE_WIDTH);
        end else begin
            intr_signal_o <= 4'b0;                  // pulses last one cycle

            if (reg_wr_en_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        border_color_o <= reg_data_i[15:8];
                        intr_signal_o  <= reg_data_i[3:0];  // software interrupt
                    end
                    XR_VID_TOP: begin
                        vid_top_o <= vres_t'(reg_data_i);
                    end
                    XR_VID_BOTTOM: begin
                        vid_bottom_o <= vres_t'(reg_data_i);
                    end
                    XR_VID_LEFT: begin
                        vid_left_o <= hres_t'(reg_data_i);
                    end
                    XR_VID_RIGHT: begin
                        vid_right_o <= hres_t'(reg_data_i);
                    end
                    XR_PA_GFX_CTRL: begin
                        colorbase_o <= reg_data_i[15:8];
                        pf_blank_o  <= reg_data_i[7];
                    end
                    default: begin
                    end
                endcase
            end

            // end of visible frame raises interrupt 3
            if (frame_end_i) begin
                intr_signal_o[3] <= 1'b1;
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        case (reg_num_i)
            XR_VID_CTRL:    reg_data_o <= {border_color_o, 4'b0, intr_status_i};
            XR_VID_TOP:     reg_data_o <= word_t'(vid_top_o);
            XR_VID_BOTTOM:  reg_data_o <= word_t'(vid_bottom_o);
            XR_VID_LEFT:    reg_data_o <= word_t'(vid_left_o);
            XR_VID_RIGHT:   reg_data_o <= word_t'(vid_right_o);
            XR_SCANLINE:    reg_data_o <= {~v_visible_i, ~h_visible_i, 14'(v_count_i)};
            XR_VID_HSIZE:   reg_data_o <= word_t'(VISIBLE_WIDTH);
            XR_VID_VSIZE:   reg_data_o <= word_t'(VISIBLE_HEIGHT);
            XR_VID_VFREQ:   reg_data_o <= word_t'(REFRESH_FREQ);
            XR_PA_GFX_CTRL: reg_data_o <= {colorbase_o, pf_blank_o, 7'b0};
            default:        reg_data_o <= 16'h0000;
        endcase
    end

endmodule
`default_nettype wire

// File: src/video_timing.sv
/*
 * video_timing
 * Horizontal and vertical sync state machines with their counters.
 * Each machine steps when its counter hits the last count of the
 * current state. Sync outputs are registered one clock behind the counters.
 */
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire logic               clk,
    input  wire logic               reset_i,
    output      video_pkg::hres_t   h_count_o,
    output      video_pkg::vres_t   v_count_o,
    output      logic               h_visible_o,
    output      logic               v_visible_o,
    output      logic               frame_end_o,    // last visible pixel of frame
    output      logic               hsync_o,
    output      logic               vsync_o
);
    import video_pkg::*;

    vid_state_t h_state;
    vid_state_t v_state;
    hres_t      h_count;
    vres_t      v_count;
    hres_t      h_last;                             // last count of current h state
    vres_t      v_last;                             // last line of current v state
    logic       line_end;
    logic       frame_wrap;                         // last pixel of whole frame

    // horizontal layout: front porch, sync, back porch, then visible
    always_comb begin
        case (h_state)
            STATE_PRE_SYNC:  h_last = hres_t'(H_FRONT_PORCH - 1);
            STATE_SYNC:      h_last = hres_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            STATE_POST_SYNC: h_last = hres_t'(OFFSCREEN_WIDTH - 1);
            default:         h_last = hres_t'(TOTAL_WIDTH - 1);
        endcase
    end

    // vertical layout: visible lines first, blanking at the bottom
    always_comb begin
        case (v_state)
            STATE_PRE_SYNC:  v_last = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
            STATE_SYNC:      v_last = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            STATE_POST_SYNC: v_last = vres_t'(TOTAL_HEIGHT - 1);
            default:         v_last = vres_t'(VISIBLE_HEIGHT - 1);
        endcase
    end

    assign line_end    = (h_state == STATE_VISIBLE) && (h_count == h_last);
    assign frame_wrap  = line_end && (v_state == STATE_POST_SYNC) && (v_count == v_last);
    assign frame_end_o = line_end && (v_state == STATE_VISIBLE) && (v_count == v_last);

    assign h_count_o   = h_count;
    assign v_count_o   = v_count;
    assign h_visible_o = (h_state == STATE_VISIBLE);
    assign v_visible_o = (v_state == STATE_VISIBLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= STATE_PRE_SYNC;
            v_state <= STATE_VISIBLE;               // start at top so first frame is whole
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~H_SYNC_POLARITY;
            vsync_o <= ~V_SYNC_POLARITY;
        end else begin
            if (h_count == h_last) begin
                h_state <= vid_state_t'(h_state + 1'b1);
            end
            h_count <= line_end ? '0 : h_count + 1'b1;

            // vertical side only moves on the last pixel of a line
            if (line_end) begin
                if (v_count == v_last) begin
                    v_state <= vid_state_t'(v_state + 1'b1);
                end
                v_count <= frame_wrap ? '0 : v_count + 1'b1;
            end

            hsync_o <= (h_state == STATE_SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (v_state == STATE_SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
        end
    end

endmodule
`default_nettype wire

// File: testbench/video_gen_tb.sv
/*
 * video_gen_tb
 * Directed testbench for the video timing and border generator.
 * Covers sync timing, display enable, register access, interrupt
 * pulses, the border window and the scanline register.
 */
`timescale 1ns/1ps

module video_gen_tb;
    import video_pkg::*;

    localparam int FRAME_CYCLES   = TOTAL_WIDTH * TOTAL_HEIGHT;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES;     // the tests take about seven frames

    logic       clk;
    logic       reset_i;
    logic       reg_wr_en_i;
    reg_num_t   reg_num_i;
    word_t      reg_data_i;
    logic [3:0] intr_status_i;
    word_t      reg_data_o;
    logic [3:0] intr_signal_o;
    color_t     color_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;
    int         cycle_count = 0;

    video_gen video_gen_i (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .intr_status_i(intr_status_i), .reg_data_o(reg_data_o),
        .intr_signal_o(intr_signal_o), .color_index_o(color_index_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    always #4 clk = ~clk;                                   // 125 MHz

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string test_name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s", test_name);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok) else begin
            $display("ERROR: %s", what);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s", what);
        end
    endtask

    task automatic write_reg(input reg_num_t num, input word_t data);
        @(posedge clk);
        reg_wr_en_i <= 1'b1;
        reg_num_i   <= num;
        reg_data_i  <= data;
        @(posedge clk);                                     // write lands on this edge
        reg_wr_en_i <= 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output word_t data);
        @(posedge clk);
        reg_num_i <= num;
        @(posedge clk);                                     // read port registers here
        @(negedge clk);
        data = reg_data_o;
    endtask

    task automatic expect_reg(input string test_name, input reg_num_t num, input int expected);
        word_t data;
        read_reg(num, data);
        check_value(test_name, expected, int'(data));
    endtask

    task automatic test_sync_timing();
        int   n;
        int   h_fall;
        int   v_fall;
        int   v_falls;
        logic h_prev;
        logic v_prev;
        @(negedge clk);
        check_cond(hsync_o && vsync_o, "sync outputs not inactive after reset");
        check_cond(!dv_de_o && intr_signal_o == 4'b0, "enable or interrupt set after reset");
        n       = 0;
        h_fall  = -1;
        v_fall  = -1;
        v_falls = 0;
        h_prev  = hsync_o;
        v_prev  = vsync_o;
        while (v_falls < 2) begin                           // two vsync falls give one period
            @(negedge clk);
            n++;
            if (h_prev && !hsync_o) begin
                if (h_fall >= 0) begin
                    check_value("test_sync_timing hsync period", TOTAL_WIDTH, n - h_fall);
                end
                h_fall = n;
            end
            if (!h_prev && hsync_o) begin
                check_value("test_sync_timing hsync width", H_SYNC_PULSE, n - h_fall);
            end
            if (v_prev && !vsync_o) begin
                if (v_falls > 0) begin
                    check_value("test_sync_timing vsync period", FRAME_CYCLES, n - v_fall);
                end
                v_fall = n;
                v_falls++;
            end
            if (!v_prev && vsync_o) begin
                check_value("test_sync_timing vsync width", V_SYNC_PULSE * TOTAL_WIDTH,
                            n - v_fall);
            end
            h_prev = hsync_o;
            v_prev = vsync_o;
        end
    endtask

    task automatic test_display_enable();
        int   total;
        int   run;
        logic de_prev;
        total   = 0;
        run     = 0;
        de_prev = dv_de_o;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (dv_de_o) begin
                total++;
                run++;
            end else if (de_prev) begin
                check_value("test_display_enable line run", VISIBLE_WIDTH, run);
                run = 0;
            end
            de_prev = dv_de_o;
        end
        check_value("test_display_enable frame count", VISIBLE_WIDTH * VISIBLE_HEIGHT, total);
    endtask

    task automatic test_registers();
        write_reg(XR_VID_LEFT, 16'd10);
        write_reg(XR_VID_RIGHT, 16'd600);
        write_reg(XR_VID_TOP, 16'd20);
        write_reg(XR_VID_BOTTOM, 16'd400);
        write_reg(XR_PA_GFX_CTRL, 16'h3380);                // colour base 0x33, blanked
        intr_status_i <= 4'ha;
        write_reg(XR_VID_CTRL, 16'h4700);                   // border 0x47, no software irq
        expect_reg("test_registers VID_LEFT", XR_VID_LEFT, 10);
        expect_reg("test_registers VID_RIGHT", XR_VID_RIGHT, 600);
        expect_reg("test_registers VID_TOP", XR_VID_TOP, 20);
        expect_reg("test_registers VID_BOTTOM", XR_VID_BOTTOM, 400);
        expect_reg("test_registers PA_GFX_CTRL", XR_PA_GFX_CTRL, 'h3380);
        expect_reg("test_registers VID_HSIZE", XR_VID_HSIZE, 640);
        expect_reg("test_registers VID_VSIZE", XR_VID_VSIZE, 480);
        expect_reg("test_registers VID_VFREQ", XR_VID_VFREQ, 60);
        expect_reg("test_registers unknown", 5'd31, 0);
        expect_reg("test_registers VID_CTRL", XR_VID_CTRL, 'h470a);
    endtask

    task automatic test_interrupts();
        int   sw_pulses;
        int   pulses;
        logic after_pulse;
        logic v_prev;
        write_reg(XR_VID_CTRL, 16'h4705);
        sw_pulses = 0;
        repeat (8) begin
            @(negedge clk);
            if (intr_signal_o != 4'b0) begin
                check_value("test_interrupts software value", 5, int'(intr_signal_o));
                sw_pulses++;
            end
        end
        check_value("test_interrupts software pulses", 1, sw_pulses);
        pulses      = 0;
        after_pulse = 1'b0;
        v_prev      = vsync_o;
        @(negedge clk);
        while (!(v_prev && !vsync_o)) begin                 // frame closes at vsync fall
            if (intr_signal_o[3]) begin
                pulses++;
                after_pulse = 1'b1;
            end else if (after_pulse) begin
                check_cond(!dv_de_o, "display enable active after the frame interrupt");
            end
            v_prev = vsync_o;
            @(negedge clk);
        end
        check_value("test_interrupts frame pulses", 1, pulses);
    endtask

    task automatic scan_border_frame(input string test_name, input int expected_window);
        int window_px;
        window_px = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (!dv_de_o) begin
                check_value({test_name, " blanking colour"}, 0, int'(color_index_o));
            end else if (color_index_o == 8'h5a) begin
                window_px++;
            end else begin
                check_value({test_name, " border colour"}, 'h21, int'(color_index_o));
            end
        end
        check_value({test_name, " window pixels"}, expected_window, window_px);
    endtask

    task automatic test_border_window();
        write_reg(XR_VID_LEFT, 16'd8);
        write_reg(XR_VID_RIGHT, 16'd16);
        write_reg(XR_VID_TOP, 16'd2);
        write_reg(XR_VID_BOTTOM, 16'd4);
        write_reg(XR_PA_GFX_CTRL, 16'h5a00);
        write_reg(XR_VID_CTRL, 16'h2100);
        scan_border_frame("test_border_window open", (16 - 8) * (4 - 2));
        write_reg(XR_PA_GFX_CTRL, 16'h5a80);                // now blank the playfield
        scan_border_frame("test_border_window blanked", 0);
    endtask

    task automatic test_scanline();
        word_t data;
        int    line;
        logic  seen_visible;
        seen_visible = 1'b0;
        line         = 0;
        while (!(seen_visible && line >= VISIBLE_HEIGHT)) begin
            read_reg(XR_SCANLINE, data);
            line = int'(data[13:0]);
            check_value("test_scanline vblank bit", (line >= VISIBLE_HEIGHT) ? 1 : 0,
                        int'(data[15]));
            if (line < VISIBLE_HEIGHT) begin
                seen_visible = 1'b1;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset_i       = 1'b1;
        reg_wr_en_i   = 1'b0;
        reg_num_i     = '0;
        reg_data_i    = '0;
        intr_status_i = 4'h0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        test_sync_timing();
        test_display_enable();
        test_registers();
        test_interrupts();
        test_border_window();
        test_scanline();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
